// ==== list.f ====
rtl/row_pkg.sv
rtl/frame_mem.sv
rtl/mem_arbiter.sv
rtl/frame_loader.sv
rtl/row_sum_ctrl.sv
rtl/row_sum_datapath.sv
rtl/row_filter_top.sv
verif/row_filter_tb.sv

// ==== Makefile ====
TOP = row_filter_tb

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== verif/row_filter_tb.sv ====
`timescale 1ns/1ps

module row_filter_tb;
    import row_pkg::*;

    localparam int COLS      = 16;
    localparam int ROWS      = 8;
    localparam int START_DLY = 2;
    localparam int pixels    = ROWS * COLS;

    logic              clk;
    logic              rst;
    logic              host_we;
    logic [addr_w-1:0] host_addr;
    logic [pix_w-1:0]  host_pixel;
    logic              host_busy;
    logic              frame_ready;
    logic              frame_done;
    logic              result_valid;
    result_t           result;

    integer            seed;
    logic [pix_w-1:0]  shadow [pixels];
    result_t           exp_q [$];
    logic              full_frame;
    logic              done_due;
    string             test_name;

    row_filter_top #(.COLS(COLS), .ROWS(ROWS), .START_DLY(START_DLY)) uut (.*);

    always #4 clk = ~clk;

    // ********************
    // checks
    // ********************

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic compare_result(input string name, input result_t expected,
                                  input result_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf(
                "error: %s expected row %0d col %0d sum %0d, actual row %0d col %0d sum %0d",
                name, expected.row, expected.col, expected.sum,
                actual.row, actual.col, actual.sum));
        end
    endtask

    task automatic compare_done(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("error: %s expected %b, actual %b", name, expected, actual));
        end
    endtask

    // sum of the four pixels that end at column c of row r.
    function automatic logic [sum_w-1:0] ref_window_sum(input int r, input int c);
        logic [sum_w-1:0] acc;
        acc = '0;
        for (int k = c - 3; k <= c; k++) begin
            acc = acc + sum_w'(shadow[r * COLS + k]);
        end
        return acc;
    endfunction

    task automatic build_expected();
        result_t e;
        exp_q.delete();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 3; c < COLS; c++) begin
                e.row = idx_w'(r);
                e.col = idx_w'(c);
                e.sum = ref_window_sum(r, c);
                exp_q.push_back(e);
            end
        end
    endtask

    // results are checked in row-major order as they come out.
    always @(posedge clk) begin : compare_results
        result_t expected;
        if (rst) begin
            done_due = 1'b0;
        end else begin
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("result_valid went high while no result was expected");
                end else begin
                    expected = exp_q.pop_front();
                    compare_result($sformatf("%s row %0d col %0d", test_name,
                                             expected.row, expected.col),
                                   expected, result);
                end
            end
            if (full_frame) begin
                compare_done($sformatf("%s frame_done one cycle after the last result",
                                       test_name),
                             done_due, frame_done);
            end
            done_due = full_frame && result_valid && (exp_q.size() == 0);
        end
    end

    // ********************
    // stimulus
    // ********************

    // the write is accepted on the next edge and then waits for the loader's grant.
    task automatic host_write(input logic [addr_w-1:0] addr, input logic [pix_w-1:0] pix);
        int n;
        n = 0;
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_pixel <= pix;
        @(posedge clk);
        host_we <= 1'b0;
        do begin
            @(posedge clk);
            n++;
            if (n == 1 && !host_busy) begin
                stop_on_error("host_busy stayed low so the host write was not accepted");
            end
            if (n > 50) begin
                stop_on_error("host_busy did not clear after a host write");
            end
        end while (host_busy);
    endtask

    task automatic wait_frame_done(input string name);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 2000) begin
                stop_on_error($sformatf("timeout while waiting for frame_done in %s", name));
            end
        end while (!frame_done);
    endtask

    task automatic run_frame(input string name);
        test_name = name;
        build_expected();
        full_frame = 1'b1;
        @(posedge clk);
        frame_ready <= 1'b1;
        wait_frame_done(name);
        frame_ready <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic run_aborted_frame(input int drop_after);
        int seen;
        int n;
        test_name = "aborted frame";
        build_expected();
        full_frame = 1'b0;
        seen = 0;
        n = 0;
        @(posedge clk);
        frame_ready <= 1'b1;
        while (seen < drop_after) begin
            @(posedge clk);
            n++;
            seen = seen + (result_valid ? 1 : 0);
            if (n > 2000) begin
                stop_on_error("timeout while waiting for results of the aborted frame");
            end
        end
        frame_ready <= 1'b0;
        wait_frame_done("aborted frame");
        repeat (20) begin
            @(posedge clk);
            compare_done("frame_done after the aborted frame", 1'b0, frame_done);
            if (result_valid) begin
                stop_on_error("result_valid went high after frame_done of the aborted frame");
            end
        end
        exp_q.delete();
    endtask

    // addresses from 512 up lie outside the frame.
    task automatic write_unused(input int count);
        repeat (10) @(posedge clk);
        for (int k = 0; k < count; k++) begin
            host_write(addr_w'(512 + ($random(seed) & 255)), pix_w'($random(seed)));
        end
    endtask

    initial begin
        logic [pix_w-1:0] pix;
        clk         = 1'b0;
        rst         = 1'b1;
        seed        = 32'hbafc;
        frame_ready = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_pixel  = '0;
        full_frame  = 1'b0;
        test_name   = "reset";
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare_done("frame_done after reset", 1'b0, frame_done);
        if (result_valid || host_busy) begin
            stop_on_error("result_valid or host_busy is high after reset");
        end
        test_name = "frame load";
        for (int a = 0; a < pixels; a++) begin
            pix = pix_w'($random(seed));
            shadow[a] = pix;
            host_write(addr_w'(a), pix);
        end
        repeat (20) @(posedge clk);
        run_frame("first frame");
        run_frame("repeated frame");
        fork
            run_frame("frame with host writes");
            write_unused(12);
        join
        run_aborted_frame(20);
        run_frame("frame after abort");
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== rtl/row_filter_top.sv ====
`timescale 1ns/1ps

module row_filter_top #(
    parameter int COLS      = 16,
    parameter int ROWS      = 8,
    parameter int START_DLY = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        host_we,
    input  logic [row_pkg::addr_w-1:0]  host_addr,
    input  logic [row_pkg::pix_w-1:0]   host_pixel,
    output logic                        host_busy,
    input  logic                        frame_ready,
    output logic                        frame_done,
    output logic                        result_valid,
    output row_pkg::result_t            result
);
    import row_pkg::*;

    // the whole address space is backed, so addresses past the frame are usable.
    localparam int mem_depth = 1 << addr_w;

    logic              start_en;
    logic              ld_en;
    logic              count_en;
    logic              sum_en;
    logic              cum_en;
    logic              emit_en;
    logic              start_gt_1;
    logic              last_row;
    logic [addr_w-1:0] pix_count;
    mem_req_t          load_req;
    mem_req_t          row_req;
    mem_req_t          mem_req;
    logic              load_gnt;
    logic              row_gnt;
    logic              row_rd_valid;
    logic [pix_w-1:0]  rd_data;

    row_sum_ctrl #(
        .COLS(COLS)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .frame_ready (frame_ready),
        .start_gt_1  (start_gt_1),
        .last_row    (last_row),
        .pix_count   (pix_count),
        .start_en    (start_en),
        .ld_en       (ld_en),
        .count_en    (count_en),
        .sum_en      (sum_en),
        .cum_en      (cum_en),
        .emit_en     (emit_en),
        .frame_done  (frame_done)
    );

    row_sum_datapath #(
        .COLS      (COLS),
        .ROWS      (ROWS),
        .START_DLY (START_DLY)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .start_en     (start_en),
        .ld_en        (ld_en),
        .count_en     (count_en),
        .sum_en       (sum_en),
        .cum_en       (cum_en),
        .emit_en      (emit_en),
        .frame_done   (frame_done),
        .gnt          (row_gnt),
        .rd_valid     (row_rd_valid),
        .rd_data      (rd_data),
        .mem_req      (row_req),
        .start_gt_1   (start_gt_1),
        .last_row     (last_row),
        .pix_count    (pix_count),
        .result_valid (result_valid),
        .result       (result)
    );

    frame_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_pixel (host_pixel),
        .gnt        (load_gnt),
        .mem_req    (load_req),
        .host_busy  (host_busy)
    );

    // the loader only writes, so its read-valid is left open.
    mem_arbiter #(
        .req_t(mem_req_t)
    ) u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .req_a      (load_req),
        .req_b      (row_req),
        .gnt_a      (load_gnt),
        .gnt_b      (row_gnt),
        .rd_valid_a (),
        .rd_valid_b (row_rd_valid),
        .mem_req    (mem_req)
    );

    frame_mem #(
        .DEPTH(mem_depth)
    ) u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_data (rd_data)
    );

endmodule

// ==== rtl/row_sum_datapath.sv ====
`timescale 1ns/1ps

module row_sum_datapath #(
    parameter int COLS      = 16,
    parameter int ROWS      = 8,
    parameter int START_DLY = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start_en,
    input  logic                        ld_en,
    input  logic                        count_en,
    input  logic                        sum_en,
    input  logic                        cum_en,
    input  logic                        emit_en,
    input  logic                        frame_done,
    input  logic                        gnt,
    input  logic                        rd_valid,
    input  logic [row_pkg::pix_w-1:0]   rd_data,
    output row_pkg::mem_req_t           mem_req,
    output logic                        start_gt_1,
    output logic                        last_row,
    output logic [row_pkg::addr_w-1:0]  pix_count,
    output logic                        result_valid,
    output row_pkg::result_t            result
);
    import row_pkg::*;

    localparam logic [addr_w-1:0] cols_a   = addr_w'(COLS);
    localparam logic [addr_w-1:0] rows_a   = addr_w'(ROWS);
    localparam logic [addr_w-1:0] dly_last = addr_w'(START_DLY - 1);

    logic [addr_w-1:0]     start_cnt;
    logic [addr_w-1:0]     col;
    logic [addr_w-1:0]     row_cnt;
    logic [addr_w-1:0]     row_base;
    logic [2:0][pix_w-1:0] win;
    logic [sum_w-1:0]      win_sum;
    logic                  take;
    logic                  issue;
    logic                  row_end;

    // ********************
    // row sequencing
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            start_cnt <= '0;
        end else if (start_en) begin
            start_cnt <= start_cnt + 1'b1;
        end else begin
            start_cnt <= '0;
        end
    end

    assign start_gt_1 = start_cnt >= dly_last;

    // the row counter moves on as the last pixel of a row comes back.
    always_ff @(posedge clk) begin
        if (rst || frame_done) begin
            row_cnt <= '0;
        end else if (row_end) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    assign last_row = row_cnt == rows_a;

    always_ff @(posedge clk) begin
        if (ld_en) begin
            row_base <= addr_w'(row_cnt * COLS);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col       <= '0;
            pix_count <= '0;
        end else begin
            if (ld_en) begin
                col <= '0;
            end else if (gnt) begin
                col <= col + 1'b1;
            end
            if (ld_en) begin
                pix_count <= '0;
            end else if (take) begin
                pix_count <= pix_count + 1'b1;
            end
        end
    end

    always_comb begin
        mem_req.req   = count_en && (col < cols_a);
        mem_req.we    = 1'b0;
        mem_req.addr  = row_base + col;
        mem_req.wdata = '0;
    end

    // ********************
    // window and sum
    // ********************

    assign take    = rd_valid && (sum_en || cum_en);
    assign row_end = rd_valid && (sum_en || emit_en) && (pix_count == cols_a - 1'b1);

    // pixels four and five can both arrive before the FSM reaches emit.
    assign issue = rd_valid && (cum_en || (sum_en && pix_count >= addr_w'(3)));

    // the incoming pixel is the fourth tap of the window.
    assign win_sum = sum_w'(rd_data) + sum_w'(win[0]) + sum_w'(win[1]) + sum_w'(win[2]);

    always_ff @(posedge clk) begin
        if (take) begin
            win <= {win[1:0], rd_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result.row <= idx_w'(row_cnt);
            result.col <= idx_w'(pix_count);
            result.sum <= win_sum;
        end
    end

endmodule

// ==== rtl/row_sum_ctrl.sv ====
`timescale 1ns/1ps

module row_sum_ctrl #(
    parameter int COLS = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frame_ready,
    input  logic                        start_gt_1,
    input  logic                        last_row,
    input  logic [row_pkg::addr_w-1:0]  pix_count,
    output logic                        start_en,
    output logic                        ld_en,
    output logic                        count_en,
    output logic                        sum_en,
    output logic                        cum_en,
    output logic                        emit_en,
    output logic                        frame_done
);
    import row_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_row_start,
        st_fill,
        st_emit,
        st_finish,
        st_done
    } state_t;

    // the window is full once four pixels of the row are in.
    localparam logic [addr_w-1:0] fill_pix = addr_w'(4);
    localparam logic [addr_w-1:0] row_pix  = addr_w'(COLS);

    state_t     state;
    state_t     state_next;
    logic       abort;
    logic [6:0] ctl;

    // a dropped frame_ready and the end of the last row both close the frame.
    assign abort = !frame_ready || last_row;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            st_idle:      state_next = frame_ready ? st_start : st_idle;
            st_start:     state_next = abort ? st_finish :
                                       start_gt_1 ? st_row_start : st_start;
            st_row_start: state_next = abort ? st_finish : st_fill;
            st_fill:      state_next = abort ? st_finish :
                                       (pix_count >= fill_pix) ? st_emit : st_fill;
            st_emit:      state_next = abort ? st_finish :
                                       (pix_count >= row_pix) ? st_row_start : st_emit;
            st_finish:    state_next = st_done;
            st_done:      state_next = frame_ready ? st_done : st_idle;
            default:      state_next = st_idle;
        endcase
    end

    // ********************
    // output decode
    // ********************

    // bit order is start, ld, count, sum, cum, emit, frame_done.
    always_comb begin
        case (state)
            st_idle:      ctl = 7'b000_0000;
            st_start:     ctl = 7'b100_0000;
            st_row_start: ctl = 7'b010_0000;
            st_fill:      ctl = 7'b001_1000;
            st_emit:      ctl = 7'b001_0110;
            st_finish:    ctl = 7'b000_0001;
            st_done:      ctl = 7'b000_0000;
            default:      ctl = 7'b000_0000;
        endcase
    end

    assign {start_en, ld_en, count_en, sum_en, cum_en, emit_en, frame_done} = ctl;

endmodule

// ==== rtl/frame_loader.sv ====
`timescale 1ns/1ps

module frame_loader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        host_we,
    input  logic [row_pkg::addr_w-1:0]  host_addr,
    input  logic [row_pkg::pix_w-1:0]   host_pixel,
    input  logic                        gnt,
    output row_pkg::mem_req_t           mem_req,
    output logic                        host_busy
);
    import row_pkg::*;

    logic              pend;
    logic              accept;
    logic [addr_w-1:0] addr_q;
    logic [pix_w-1:0]  pixel_q;

    assign accept = host_we && !pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (gnt) begin
            pend <= 1'b0;
        end else if (accept) begin
            pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= host_addr;
            pixel_q <= host_pixel;
        end
    end

    assign host_busy = pend;

    always_comb begin
        mem_req.req   = pend;
        mem_req.we    = 1'b1;
        mem_req.addr  = addr_q;
        mem_req.wdata = pixel_q;
    end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter #(
    parameter type req_t = row_pkg::mem_req_t
) (
    input  logic clk,
    input  logic rst,
    input  req_t req_a,
    input  req_t req_b,
    output logic gnt_a,
    output logic gnt_b,
    output logic rd_valid_a,
    output logic rd_valid_b,
    output req_t mem_req
);

    logic last_b;
    logic rd_pend;
    logic rd_owner_b;

    // on a tie the requester that did not win last time gets the port.
    always_comb begin
        if (req_a.req && req_b.req) begin
            gnt_a = last_b;
            gnt_b = !last_b;
        end else begin
            gnt_a = req_a.req;
            gnt_b = req_b.req;
        end
    end

    // with no grant req_a is idle, so its req bit keeps the port quiet.
    assign mem_req = gnt_b ? req_b : req_a;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_b  <= 1'b1;
            rd_pend <= 1'b0;
        end else begin
            if (gnt_a || gnt_b) begin
                last_b <= gnt_b;
            end
            rd_pend <= (gnt_a || gnt_b) && !mem_req.we;
        end
    end

    always_ff @(posedge clk) begin
        rd_owner_b <= gnt_b;
    end

    assign rd_valid_a = rd_pend && !rd_owner_b;
    assign rd_valid_b = rd_pend && rd_owner_b;

endmodule

// ==== rtl/frame_mem.sv ====
`timescale 1ns/1ps

module frame_mem #(
    parameter int DEPTH = 1024
) (
    input  logic                       clk,
    input  row_pkg::mem_req_t          mem_req,
    output logic [row_pkg::pix_w-1:0]  rd_data
);
    import row_pkg::*;

    logic [pix_w-1:0] mem [DEPTH];

    // rd_data holds its value between reads.
    always_ff @(posedge clk) begin
        if (mem_req.req) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rd_data <= mem[mem_req.addr];
            end
        end
    end

endmodule

// ==== rtl/row_pkg.sv ====
package row_pkg;

    // ********************
    // widths
    // ********************

    localparam int pix_w  = 8;
    localparam int sum_w  = pix_w + 2;
    localparam int addr_w = 10;

    // row and column fields of a result.
    localparam int idx_w  = 5;

    // ********************
    // bus payloads
    // ********************

    // one memory access, either a pixel write or a pixel read.
    typedef struct packed {
        logic              req;
        logic              we;
        logic [addr_w-1:0] addr;
        logic [pix_w-1:0]  wdata;
    } mem_req_t;

    // one windowed sum, tagged with the column of its newest pixel.
    typedef struct packed {
        logic [idx_w-1:0] row;
        logic [idx_w-1:0] col;
        logic [sum_w-1:0] sum;
    } result_t;

endpackage
